// ==== flist.f ====
eth_mon_pkg.sv
eth_mon_tap.sv
eth_mon_capture.sv
eth_mon_capture_ram.sv
eth_mon_axil_regs.sv
eth_stream_monitor.sv
eth_mon_assert.sv
tb_eth_stream_monitor.sv

// ==== Bender.yml ====
package:
  name: eth_stream_monitor

sources:
  - files:
      - eth_mon_pkg.sv
      - eth_mon_tap.sv
      - eth_mon_capture.sv
      - eth_mon_capture_ram.sv
      - eth_mon_axil_regs.sv
      - eth_stream_monitor.sv
  - target: test
    files:
      - eth_mon_assert.sv
      - tb_eth_stream_monitor.sv

// ==== tb_eth_stream_monitor.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_eth_stream_monitor
    import eth_mon_pkg::*;
();

    localparam int CAPT_DEPTH = 32;
    localparam int MAX_CYCLES = 4000;

    logic      clk_stream;
    logic      rst_n;
    eth_beat_t in_beat;
    eth_beat_t out_beat;
    eth_beat_t exp_beat;
    axil_req_t req;
    axil_rsp_t rsp;

    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        exp_pkts = 0;
    int        total_errors;
    eth_beat_t pkt_q[$];

    eth_stream_monitor #(
        .P_CAPT_DEPTH (CAPT_DEPTH)
    ) eth_stream_monitor_inst (
        .i_clk_stream (clk_stream),
        .i_rst_n      (rst_n),
        .i_eths_beat  (in_beat),
        .o_eths_beat  (out_beat),
        .i_axil_req   (req),
        .o_axil_rsp   (rsp)
    );

    initial begin
        clk_stream = 1'b0;
        forever #2 clk_stream = ~clk_stream;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_stream);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // output must equal the input one cycle later
    always @(posedge clk_stream) begin
        exp_beat <= in_beat;
    end

    always @(negedge clk_stream) begin
        if (rst_n) begin
            check("o_eths_beat", 64'(out_beat), 64'(exp_beat));
        end
    end

    task automatic drive_beat(input eth_beat_t beat);
        @(negedge clk_stream);
        in_beat = beat;
    endtask

    // beats back to back, then one idle beat
    task automatic send_packet(input int n, input logic [31:0] seed);
        eth_beat_t beat;
        pkt_q.delete();
        for (int i = 0; i < n; i++) begin
            beat.data  = $urandom ^ seed;
            beat.last  = (i == n - 1);
            beat.keep  = beat.last ? 2'($urandom) : 2'd0;
            beat.abort = 1'b0;
            beat.valid = 1'b1;
            pkt_q.push_back(beat);
            drive_beat(beat);
        end
        beat = '0;
        beat.data = $urandom;
        drive_beat(beat);
        exp_pkts++;
    endtask

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data, input int hold);
        int lat;
        @(negedge clk_stream);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hf;
        req.wvalid  = 1'b1;
        req.bready  = 1'b0;
        // both ready lines pulse in the acceptance cycle
        #1;
        check("awready", rsp.awready, 1'b1);
        check("wready", rsp.wready, 1'b1);
        lat = 0;
        do begin
            @(negedge clk_stream);
            req.awvalid = 1'b0;
            req.wvalid  = 1'b0;
            lat++;
        end while (!rsp.bvalid);
        check("bvalid latency", lat, 1);
        check("bresp", rsp.bresp, RESP_OKAY);
        repeat (hold) begin
            @(negedge clk_stream);
            check("bvalid", rsp.bvalid, 1'b1);
        end
        req.bready = 1'b1;
        @(negedge clk_stream);
        check("bvalid", rsp.bvalid, 1'b0);
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, input int hold, output logic [31:0] data);
        int lat;
        @(negedge clk_stream);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = 1'b0;
        #1;
        check("arready", rsp.arready, 1'b1);
        lat = 0;
        do begin
            @(negedge clk_stream);
            req.arvalid = 1'b0;
            lat++;
        end while (!rsp.rvalid);
        // window reads take one extra cycle for the memory
        check("rvalid latency", lat, (addr >= CAPT_WIN_BASE) ? 2 : 1);
        check("rresp", rsp.rresp, RESP_OKAY);
        data = rsp.rdata;
        repeat (hold) begin
            @(negedge clk_stream);
            check("rvalid", rsp.rvalid, 1'b1);
            check("rdata", rsp.rdata, data);
        end
        req.rready = 1'b1;
        @(negedge clk_stream);
        check("rvalid", rsp.rvalid, 1'b0);
        req.rready = 1'b0;
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] got;
        axil_read(addr, 0, got);
        check(name, got, exp);
    endtask

    // data word of entry i at 8*i and info word at 8*i+4
    task automatic check_entry(input int idx, input eth_beat_t beat);
        logic [15:0] addr;
        addr = CAPT_WIN_BASE + 16'(8 * idx);
        read_expect(addr, beat.data, $sformatf("capture data %0d", idx));
        read_expect(addr + 16'd4, {27'd0, beat.abort, beat.valid, beat.last, beat.keep},
                    $sformatf("capture info %0d", idx));
    endtask

    task automatic stream_passthrough();
        eth_beat_t beat;
        check("o_eths_beat.valid after reset", out_beat.valid, 1'b0);
        send_packet(3, 32'h1111_0000);
        repeat (4) begin
            beat = {$urandom, 5'b00000};
            drive_beat(beat);
        end
    endtask

    task automatic count_packets();
        eth_beat_t beat;
        read_expect(REG_PKT_COUNT, exp_pkts, "pkt_count");
        repeat (3) send_packet(4, 32'h0000_00a5);
        read_expect(REG_PKT_COUNT, exp_pkts, "pkt_count");
        // last without valid, then an abort beat without last
        beat = {$urandom, 2'd3, 1'b1, 1'b0, 1'b0};
        drive_beat(beat);
        beat = {$urandom, 2'd0, 1'b0, 1'b1, 1'b1};
        drive_beat(beat);
        drive_beat('0);
        read_expect(REG_PKT_COUNT, exp_pkts, "pkt_count after abort");
        send_packet(2, 32'h0000_5a00);
        read_expect(REG_PKT_COUNT, exp_pkts, "pkt_count");
    endtask

    task automatic capture_next_packet();
        // arm while a packet is already running
        fork
            send_packet(8, 32'h5500_0000);
            begin
                repeat (2) @(negedge clk_stream);
                axil_write(REG_TRIGGER, 32'h1, 0);
            end
        join
        read_expect(REG_TRIGGER, 32'h1, "trigger busy");
        // second arm lands during the capture
        fork
            send_packet(5, 32'h0a0a_0000);
            begin
                repeat (2) @(negedge clk_stream);
                axil_write(REG_TRIGGER, 32'h1, 0);
            end
        join
        read_expect(REG_CAPT_LEN, 32'd5, "capt_len");
        read_expect(REG_TRIGGER, 32'h0, "trigger done");
        for (int i = 0; i < 5; i++) begin
            check_entry(i, pkt_q[i]);
        end
    endtask

    task automatic overflow_capture();
        axil_write(REG_TRIGGER, 32'h1, 0);
        read_expect(REG_TRIGGER, 32'h1, "trigger busy");
        send_packet(40, 32'hc0de_0000);
        read_expect(REG_CAPT_LEN, CAPT_DEPTH, "capt_len capped");
        read_expect(REG_TRIGGER, 32'h0, "trigger done");
        check_entry(0, pkt_q[0]);
        check_entry(CAPT_DEPTH - 1, pkt_q[CAPT_DEPTH-1]);
    endtask

    task automatic axil_responses();
        logic [31:0] data;
        read_expect(16'h0010, 32'h0, "unmapped read");
        read_expect(16'h0ffc, 32'h0, "unmapped read");
        read_expect(CAPT_WIN_BASE + 16'(8 * CAPT_DEPTH), 32'h0, "window past depth");
        axil_write(REG_PKT_COUNT, 32'hffff_ffff, 0);
        // bready held low for a few cycles
        axil_write(REG_CAPT_LEN, 32'h0000_0077, 3);
        axil_write(REG_TRIGGER, 32'h0000_0002, 2);
        read_expect(REG_PKT_COUNT, exp_pkts, "pkt_count after write");
        read_expect(REG_CAPT_LEN, CAPT_DEPTH, "capt_len after write");
        read_expect(REG_TRIGGER, 32'h0, "trigger without arm bit");
        // data must not move while rready is low
        axil_read(REG_PKT_COUNT, 4, data);
        check("pkt_count held read", data, exp_pkts);
        axil_read(CAPT_WIN_BASE + 16'(8 * (CAPT_DEPTH - 1)), 3, data);
        check("window held read", data, pkt_q[CAPT_DEPTH-1].data);
    endtask

    initial begin
        void'($urandom(32'h3bc0e01f));
        in_beat = '0;
        req     = '0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk_stream);
        @(negedge clk_stream);
        rst_n = 1'b1;

        stream_passthrough();
        count_packets();
        capture_next_packet();
        overflow_capture();
        axil_responses();
        repeat (4) @(negedge clk_stream);

        total_errors = errors +
            eth_stream_monitor_inst.eth_mon_axil_regs_inst.eth_mon_assert_inst.assert_errors;
        $display("checks: %0d, errors: %0d", checks, total_errors);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_mon_assert.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_mon_assert
    import eth_mon_pkg::*;
(
    input wire            i_clk_stream,
    input wire            i_rst_n,
    input wire axil_req_t i_axil_req,
    input wire axil_rsp_t i_axil_rsp
);

    // number of failed assertions, summed into the testbench verdict
    int assert_errors = 0;

    // write response holds until the manager takes it
    bvalid_hold: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        i_axil_rsp.bvalid && !i_axil_req.bready |=> i_axil_rsp.bvalid)
        else begin
            $error("bvalid dropped before bready");
            assert_errors++;
        end

    // read response and its data hold until rready
    rvalid_hold: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        i_axil_rsp.rvalid && !i_axil_req.rready |=>
            i_axil_rsp.rvalid && $stable(i_axil_rsp.rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            assert_errors++;
        end

    // no response leaves the slave while reset is applied
    resp_low_in_reset: assert property (@(posedge i_clk_stream)
        !i_rst_n |=> !i_axil_rsp.bvalid && !i_axil_rsp.rvalid)
        else begin
            $error("response valid during reset");
            assert_errors++;
        end

endmodule

bind eth_mon_axil_regs eth_mon_assert eth_mon_assert_inst (
    .i_clk_stream (i_clk_stream),
    .i_rst_n      (i_rst_n),
    .i_axil_req   (i_axil_req),
    .i_axil_rsp   (o_axil_rsp)
);

`default_nettype wire

// ==== eth_stream_monitor.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_stream_monitor
    import eth_mon_pkg::*;
#(
    parameter int P_CAPT_DEPTH = 32
) (
    input  wire            i_clk_stream,
    input  wire            i_rst_n,
    input  wire eth_beat_t i_eths_beat,
    output eth_beat_t      o_eths_beat,
    input  wire axil_req_t i_axil_req,
    output axil_rsp_t      o_axil_rsp
);

    localparam int AW = $clog2(P_CAPT_DEPTH);

    logic          bus_idle;
    logic [31:0]   pkt_count;
    logic          arm;
    logic          busy;
    logic [31:0]   capt_len;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    eth_beat_t     wr_row;
    logic [AW-1:0] rd_addr;
    eth_beat_t     rd_row;

    // the registered beat feeds both the output and the capture FSM
    eth_mon_tap eth_mon_tap_inst (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_eths_beat  (i_eths_beat),
        .o_eths_beat  (o_eths_beat),
        .o_bus_idle   (bus_idle),
        .o_pkt_count  (pkt_count)
    );

    eth_mon_capture #(
        .P_CAPT_DEPTH (P_CAPT_DEPTH)
    ) eth_mon_capture_inst (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_beat       (o_eths_beat),
        .i_bus_idle   (bus_idle),
        .i_arm        (arm),
        .o_busy       (busy),
        .o_capt_len   (capt_len),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_row     (wr_row)
    );

    eth_mon_capture_ram #(
        .P_CAPT_DEPTH (P_CAPT_DEPTH)
    ) eth_mon_capture_ram_inst (
        .i_clk_stream (i_clk_stream),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_row     (wr_row),
        .i_rd_addr    (rd_addr),
        .o_rd_row     (rd_row)
    );

    eth_mon_axil_regs #(
        .P_CAPT_DEPTH (P_CAPT_DEPTH)
    ) eth_mon_axil_regs_inst (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_axil_req   (i_axil_req),
        .o_axil_rsp   (o_axil_rsp),
        .i_pkt_count  (pkt_count),
        .i_busy       (busy),
        .i_capt_len   (capt_len),
        .o_arm        (arm),
        .o_rd_addr    (rd_addr),
        .i_rd_row     (rd_row)
    );

endmodule

`default_nettype wire

// ==== eth_mon_axil_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_mon_axil_regs
    import eth_mon_pkg::*;
#(
    parameter int P_CAPT_DEPTH = 32
) (
    input  wire                               i_clk_stream,
    input  wire                               i_rst_n,
    input  wire axil_req_t                    i_axil_req,
    output axil_rsp_t                         o_axil_rsp,
    input  wire [31:0]                        i_pkt_count,
    input  wire                               i_busy,
    input  wire [31:0]                        i_capt_len,
    output logic                              o_arm,
    output logic [$clog2(P_CAPT_DEPTH)-1:0]   o_rd_addr,
    input  wire eth_beat_t                    i_rd_row
);

    localparam int AW = $clog2(P_CAPT_DEPTH);
    // bytes covered by the capture window, 8 per entry
    localparam logic [AXIL_ADDR_W-1:0] WIN_SPAN = AXIL_ADDR_W'(8 * P_CAPT_DEPTH);

    logic                   bvalid_q;
    logic                   rvalid_q;
    logic                   win_pend_q;
    logic                   win_hit_q;
    logic                   info_sel_q;
    logic [AXIL_DATA_W-1:0] rdata_q;

    logic                   pending;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   in_win;
    logic                   win_hit;
    logic [AXIL_ADDR_W-1:0] win_off;
    logic [AXIL_DATA_W-1:0] reg_rdata;
    logic [AXIL_DATA_W-1:0] win_rdata;

    // one transaction in flight, a window read counts until rvalid
    assign pending   = bvalid_q || rvalid_q || win_pend_q;
    assign wr_accept = i_axil_req.awvalid && i_axil_req.wvalid && !pending;
    // writes win when both arrive together
    assign rd_accept = i_axil_req.arvalid && !pending && !wr_accept;

    assign o_arm = wr_accept && (i_axil_req.awaddr == REG_TRIGGER) && i_axil_req.wdata[0];

    // capture window decode
    assign in_win    = i_axil_req.araddr >= CAPT_WIN_BASE;
    assign win_off   = i_axil_req.araddr - CAPT_WIN_BASE;
    assign win_hit   = in_win && (win_off < WIN_SPAN);
    assign o_rd_addr = win_off[AW+2:3];

    always_comb begin
        case (i_axil_req.araddr)
            REG_PKT_COUNT: reg_rdata = i_pkt_count;
            REG_TRIGGER:   reg_rdata = {{(AXIL_DATA_W-1){1'b0}}, i_busy};
            REG_CAPT_LEN:  reg_rdata = i_capt_len;
            default:       reg_rdata = '0;
        endcase
    end

    // info word is keep, last, valid, abort from bit 0 up
    always_comb begin
        if (!win_hit_q) begin
            win_rdata = '0;
        end else if (info_sel_q) begin
            win_rdata = {{(AXIL_DATA_W-5){1'b0}}, i_rd_row.abort, i_rd_row.valid,
                         i_rd_row.last, i_rd_row.keep};
        end else begin
            win_rdata = i_rd_row.data;
        end
    end

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            win_pend_q <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (bvalid_q && i_axil_req.bready) begin
                bvalid_q <= 1'b0;
            end

            // window reads spend one cycle on the memory
            win_pend_q <= rd_accept && in_win;

            if ((rd_accept && !in_win) || win_pend_q) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && i_axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // read data only moves while no response is outstanding
    always_ff @(posedge i_clk_stream) begin
        if (rd_accept) begin
            win_hit_q  <= win_hit;
            info_sel_q <= i_axil_req.araddr[2];
        end
        if (rd_accept && !in_win) begin
            rdata_q <= reg_rdata;
        end else if (win_pend_q) begin
            rdata_q <= win_rdata;
        end
    end

    always_comb begin
        o_axil_rsp.awready = wr_accept;
        o_axil_rsp.wready  = wr_accept;
        o_axil_rsp.bvalid  = bvalid_q;
        o_axil_rsp.bresp   = RESP_OKAY;
        o_axil_rsp.arready = rd_accept;
        o_axil_rsp.rvalid  = rvalid_q;
        o_axil_rsp.rdata   = rdata_q;
        o_axil_rsp.rresp   = RESP_OKAY;
    end

endmodule

`default_nettype wire

// ==== eth_mon_capture_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_mon_capture_ram
    import eth_mon_pkg::*;
#(
    parameter int P_CAPT_DEPTH = 32
) (
    input  wire                               i_clk_stream,
    input  wire                               i_wr_en,
    input  wire [$clog2(P_CAPT_DEPTH)-1:0]    i_wr_addr,
    input  wire eth_beat_t                    i_wr_row,
    input  wire [$clog2(P_CAPT_DEPTH)-1:0]    i_rd_addr,
    output eth_beat_t                         o_rd_row
);

    // one full beat per entry
    eth_beat_t mem [P_CAPT_DEPTH];

    always_ff @(posedge i_clk_stream) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_row;
        end
    end

    // registered read port, row appears one cycle after the address
    always_ff @(posedge i_clk_stream) begin
        o_rd_row <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// ==== eth_mon_capture.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_mon_capture
    import eth_mon_pkg::*;
#(
    parameter int P_CAPT_DEPTH = 32
) (
    input  wire                               i_clk_stream,
    input  wire                               i_rst_n,
    input  wire eth_beat_t                    i_beat,
    input  wire                               i_bus_idle,
    input  wire                               i_arm,
    output logic                              o_busy,
    output logic [31:0]                       o_capt_len,
    output logic                              o_wr_en,
    output logic [$clog2(P_CAPT_DEPTH)-1:0]   o_wr_addr,
    output eth_beat_t                         o_wr_row
);

    localparam int AW = $clog2(P_CAPT_DEPTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_CAPT,
        S_DONE
    } state_t;

    state_t      state_q;
    // one bit wider than the address so a full memory is visible in the MSB
    logic [AW:0] cnt_q;
    logic        start;
    logic        store;

    // first valid beat once the stream sits between packets
    assign start = (state_q == S_WAIT) && i_bus_idle && i_beat.valid;

    // only valid beats are stored, and nothing past the depth
    assign store = (start || ((state_q == S_CAPT) && i_beat.valid)) && !cnt_q[AW];

    assign o_busy     = (state_q == S_WAIT) || (state_q == S_CAPT);
    assign o_capt_len = 32'(cnt_q);
    assign o_wr_en    = store;
    assign o_wr_addr  = cnt_q[AW-1:0];
    assign o_wr_row   = i_beat;

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            if (store) begin
                cnt_q <= cnt_q + 1'b1;
            end

            case (state_q)
                S_IDLE, S_DONE: begin
                    // a new arm drops the previous result
                    if (i_arm) begin
                        state_q <= S_WAIT;
                        cnt_q   <= '0;
                    end
                end
                S_WAIT: begin
                    if (start) begin
                        // single-beat packet ends the capture right away
                        state_q <= i_beat.last ? S_DONE : S_CAPT;
                    end
                end
                S_CAPT: begin
                    if (i_beat.valid && i_beat.last) begin
                        state_q <= S_DONE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== eth_mon_tap.sv ====
`default_nettype none
`timescale 1ns/10ps

module eth_mon_tap
    import eth_mon_pkg::*;
(
    input  wire            i_clk_stream,
    input  wire            i_rst_n,
    input  wire eth_beat_t i_eths_beat,
    output eth_beat_t      o_eths_beat,
    output logic           o_bus_idle,
    output logic [31:0]    o_pkt_count
);

    logic        valid_q;
    logic        last_q;
    logic        abort_q;
    logic [31:0] data_q;
    logic [1:0]  keep_q;
    logic        idle_q;
    logic [31:0] count_q;

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            abort_q <= 1'b0;
        end else begin
            valid_q <= i_eths_beat.valid;
            last_q  <= i_eths_beat.last;
            abort_q <= i_eths_beat.abort;
        end
    end

    always_ff @(posedge i_clk_stream) begin
        data_q <= i_eths_beat.data;
        keep_q <= i_eths_beat.keep;
    end

    always_comb begin
        o_eths_beat.data  = data_q;
        o_eths_beat.keep  = keep_q;
        o_eths_beat.last  = last_q;
        o_eths_beat.abort = abort_q;
        o_eths_beat.valid = valid_q;
    end

    // packet boundary tracking and packet count on the registered stream
    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idle_q  <= 1'b1;
            count_q <= '0;
        end else if (valid_q) begin
            idle_q <= last_q;
            // saturate at all ones
            if (last_q && (count_q != '1)) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign o_bus_idle  = idle_q;
    assign o_pkt_count = count_q;

endmodule

`default_nettype wire

// ==== eth_mon_pkg.sv ====
`default_nettype none

package eth_mon_pkg;

    // AXI4-Lite bus widths
    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_DATA_W = 32;

    // one beat of the Ethernet stream
    // keep counts the valid bytes in the last beat of a packet
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  keep;
        logic        last;
        logic        abort;
        logic        valid;
    } eth_beat_t;

    // manager to slave
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    // slave to manager
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    // register map
    localparam logic [AXIL_ADDR_W-1:0] REG_PKT_COUNT = 16'h0000;
    localparam logic [AXIL_ADDR_W-1:0] REG_TRIGGER   = 16'h0004;
    localparam logic [AXIL_ADDR_W-1:0] REG_CAPT_LEN  = 16'h0008;

    // capture window, two words per entry (data then info)
    localparam logic [AXIL_ADDR_W-1:0] CAPT_WIN_BASE = 16'h1000;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
